// ==== source/ifm_buffer_pkg.sv ====
package ifm_buffer_pkg;

	// feature map geometry.
	localparam int data_width = 32;
	localparam int ifm_size = 26;
	localparam int ifm_depth = ifm_size * ifm_size; // 676 words, one map per lane.
	localparam int addr_width = $clog2(ifm_depth);

	// ring organisation.
	localparam int num_lanes = 3;
	localparam int num_groups = 6;
	localparam int phase_width = $clog2(num_groups); // codes 6 and 7 select no group.

	typedef logic [addr_width-1:0] ifm_addr_t;
	typedef logic [data_width-1:0] ifm_word_t;

	// lane 0 sits in the low bits.
	typedef ifm_word_t [num_lanes-1:0] ifm_lanes_t;

	typedef struct packed
	{
		logic en;
		ifm_addr_t addr;
		ifm_lanes_t data;
	} ifm_write_t;

	typedef struct packed
	{
		logic en;
		ifm_addr_t addr;
	} ifm_read_t;

	typedef struct packed
	{
		logic valid;
		ifm_lanes_t data;
	} ifm_read_data_t;

	// one group sees at most a producer write, one port A read and one port B read per cycle.
	typedef struct packed
	{
		logic wr_en;
		ifm_addr_t wr_addr;
		logic rd_a_en;
		ifm_addr_t rd_a_addr;
		logic rd_b_en;
		ifm_addr_t rd_b_addr;
	} ifm_port_cmd_t;

endpackage

// ==== source/ifm_lane_ram.sv ====
`timescale 1ns/100ps

module ifm_lane_ram
	import ifm_buffer_pkg::*;
(
	input logic clk,

	// port A, shared between the producer write and the consumer A read.
	input logic wr_en,
	input ifm_addr_t wr_addr,
	input ifm_word_t wr_data,
	input logic rd_a_en,
	input ifm_addr_t rd_a_addr,
	output ifm_word_t rd_a_data,

	// port B, read only.
	input logic rd_b_en,
	input ifm_addr_t rd_b_addr,
	output ifm_word_t rd_b_data
);

	ifm_word_t mem [ifm_depth];

	always_ff @(posedge clk)
	begin
		if (wr_en)
		begin
			mem[wr_addr] <= wr_data;
		end
	end

	// both reads sample the array before this edge's write lands, so a same-cycle
	// read of the written address returns the old word.
	always_ff @(posedge clk)
	begin
		if (rd_a_en)
		begin
			rd_a_data <= mem[rd_a_addr];
		end
	end

	always_ff @(posedge clk)
	begin
		if (rd_b_en)
		begin
			rd_b_data <= mem[rd_b_addr]; // holds its last word while idle.
		end
	end

endmodule

// ==== source/ifm_bank_group.sv ====
`timescale 1ns/100ps

module ifm_bank_group
	import ifm_buffer_pkg::*;
(
	input logic clk,
	input ifm_port_cmd_t cmd,
	input ifm_lanes_t wr_data,
	output ifm_lanes_t rd_a_data,
	output ifm_lanes_t rd_b_data
);

	// all three lanes run in lock step on one address per port.
	// only the data is split per lane.
	for (genvar l = 0; l < num_lanes; l++)
	begin : g_lane
		ifm_lane_ram ifm_lane_ram_inst
		(
			.clk(clk),
			.wr_en(cmd.wr_en),
			.wr_addr(cmd.wr_addr),
			.wr_data(wr_data[l]),
			.rd_a_en(cmd.rd_a_en),
			.rd_a_addr(cmd.rd_a_addr),
			.rd_a_data(rd_a_data[l]),
			.rd_b_en(cmd.rd_b_en),
			.rd_b_addr(cmd.rd_b_addr),
			.rd_b_data(rd_b_data[l])
		);
	end

endmodule

// ==== source/ifm_bank_switch.sv ====
`timescale 1ns/100ps

module ifm_bank_switch
	import ifm_buffer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [phase_width-1:0] phase,

	// producer side.
	input ifm_write_t prev_wr,
	input ifm_read_t prev_rd,

	// consumer side.
	input ifm_read_t next_rd_a,
	input ifm_read_t next_rd_b,

	// towards the ring of groups.
	output ifm_port_cmd_t group_cmd [num_groups],
	input ifm_lanes_t group_rd_a [num_groups],
	input ifm_lanes_t group_rd_b [num_groups],

	// responses.
	output ifm_read_data_t prev_rd_data,
	output ifm_read_data_t next_rd_a_data,
	output ifm_read_data_t next_rd_b_data
);

	logic phase_ok;
	logic [phase_width-1:0] prod_grp;
	logic [phase_width-1:0] cons_grp;

	logic prev_valid_q;
	logic next_a_valid_q;
	logic next_b_valid_q;
	logic [phase_width-1:0] prev_grp_q;
	logic [phase_width-1:0] next_a_grp_q;
	logic [phase_width-1:0] next_b_grp_q;

	assign phase_ok = (phase < phase_width'(num_groups));
	assign prod_grp = phase;

	// the consumer reads the group written in the previous phase, wrapping 0 back to 5.
	assign cons_grp = (phase == '0) ? phase_width'(num_groups - 1) : phase - 1'b1;

	// each group takes its command from whichever side owns it this phase.
	// an unowned group, or any group under an invalid phase, stays idle.
	always_comb
	begin
		for (int g = 0; g < num_groups; g++)
		begin
			group_cmd[g] = '0;
			if (phase_ok && (prod_grp == phase_width'(g)))
			begin
				group_cmd[g].wr_en = prev_wr.en;
				group_cmd[g].wr_addr = prev_wr.addr;
				group_cmd[g].rd_b_en = prev_rd.en; // producer read-back uses port B.
				group_cmd[g].rd_b_addr = prev_rd.addr;
			end
			if (phase_ok && (cons_grp == phase_width'(g)))
			begin
				group_cmd[g].rd_a_en = next_rd_a.en;
				group_cmd[g].rd_a_addr = next_rd_a.addr;
				group_cmd[g].rd_b_en = next_rd_b.en;
				group_cmd[g].rd_b_addr = next_rd_b.addr;
			end
		end
	end

	// remember which group answers each read, since phase may move on
	// before the data comes back.
	always_ff @(posedge clk)
	begin
		if (rst)
		begin
			prev_valid_q <= 1'b0;
			next_a_valid_q <= 1'b0;
			next_b_valid_q <= 1'b0;
			prev_grp_q <= '0;
			next_a_grp_q <= '0;
			next_b_grp_q <= '0;
		end
		else
		begin
			prev_valid_q <= prev_rd.en && phase_ok;
			next_a_valid_q <= next_rd_a.en && phase_ok;
			next_b_valid_q <= next_rd_b.en && phase_ok;

			// the indices only move on accepted reads and so never leave 0 to 5.
			if (prev_rd.en && phase_ok)
			begin
				prev_grp_q <= prod_grp;
			end
			if (next_rd_a.en && phase_ok)
			begin
				next_a_grp_q <= cons_grp;
			end
			if (next_rd_b.en && phase_ok)
			begin
				next_b_grp_q <= cons_grp;
			end
		end
	end

	always_comb
	begin
		prev_rd_data.valid = prev_valid_q;
		prev_rd_data.data = group_rd_b[prev_grp_q];

		next_rd_a_data.valid = next_a_valid_q;
		next_rd_a_data.data = group_rd_a[next_a_grp_q];

		next_rd_b_data.valid = next_b_valid_q;
		next_rd_b_data.data = group_rd_b[next_b_grp_q];
	end

endmodule

// ==== source/ifm_rotating_buffer.sv ====
`timescale 1ns/100ps

module ifm_rotating_buffer
	import ifm_buffer_pkg::*;
(
	input logic clk,
	input logic rst,
	input logic [phase_width-1:0] phase,

	input ifm_write_t prev_wr,
	input ifm_read_t prev_rd,
	output ifm_read_data_t prev_rd_data,

	input ifm_read_t next_rd_a,
	input ifm_read_t next_rd_b,
	output ifm_read_data_t next_rd_a_data,
	output ifm_read_data_t next_rd_b_data
);

	ifm_port_cmd_t group_cmd [num_groups];
	ifm_lanes_t group_rd_a [num_groups];
	ifm_lanes_t group_rd_b [num_groups];

	ifm_bank_switch ifm_bank_switch_inst
	(
		.clk(clk),
		.rst(rst),
		.phase(phase),
		.prev_wr(prev_wr),
		.prev_rd(prev_rd),
		.next_rd_a(next_rd_a),
		.next_rd_b(next_rd_b),
		.group_cmd(group_cmd),
		.group_rd_a(group_rd_a),
		.group_rd_b(group_rd_b),
		.prev_rd_data(prev_rd_data),
		.next_rd_a_data(next_rd_a_data),
		.next_rd_b_data(next_rd_b_data)
	);

	// producer lanes fan out to every group and only the one holding wr_en stores them.
	for (genvar g = 0; g < num_groups; g++)
	begin : g_group
		ifm_bank_group ifm_bank_group_inst
		(
			.clk(clk),
			.cmd(group_cmd[g]),
			.wr_data(prev_wr.data),
			.rd_a_data(group_rd_a[g]),
			.rd_b_data(group_rd_b[g])
		);
	end

endmodule

// ==== tb/ifm_buffer_tests.svh ====
task automatic idle_requests();
	req_wr = '0;
	req_prev_rd = '0;
	req_rd_a = '0;
	req_rd_b = '0;
endtask

// one idle cycle lets the last response come back and be checked.
task automatic flush(input string name);
	idle_requests();
	clock_cycle(name);
endtask

task automatic fill_random(input string name, input int n);
	addr_list.delete();
	for (int i = 0; i < n; i++)
	begin
		req_wr.en = 1'b1;
		req_wr.addr = random_addr();
		req_wr.data = random_lanes();
		addr_list.push_back(req_wr.addr);
		clock_cycle(name);
	end
	req_wr = '0;
endtask

function automatic logic any_written(input int a);
	for (int g = 0; g < num_groups; g++)
	begin
		if (written[g][a])
			return 1'b1;
	end
	return 1'b0;
endfunction

task automatic reset_valid_test();
	idle_requests();
	req_phase = '0;
	repeat (2) clock_cycle("reset_valid"); // flags must stay low straight out of reset.
	req_prev_rd = read_cmd(ifm_addr_t'(1));
	clock_cycle("reset_valid");
	idle_requests();
	repeat (2) clock_cycle("reset_valid");
	req_rd_a = read_cmd(ifm_addr_t'(2));
	clock_cycle("reset_valid");
	idle_requests();
	repeat (2) clock_cycle("reset_valid");
	req_rd_b = read_cmd(ifm_addr_t'(3));
	clock_cycle("reset_valid");
	idle_requests();
	clock_cycle("reset_valid");
	req_prev_rd = read_cmd(ifm_addr_t'(4));
	req_rd_a = read_cmd(ifm_addr_t'(5));
	req_rd_b = read_cmd(ifm_addr_t'(6));
	repeat (2) clock_cycle("reset_valid");
	flush("reset_valid");
	clock_cycle("reset_valid");
endtask

task automatic write_read_test();
	idle_requests();
	req_phase = phase_width'(2);
	fill_random("write_read", num_words);
	for (int i = 0; i < addr_list.size(); i++)
	begin
		req_prev_rd = read_cmd(addr_list[i]); // back to back reads.
		clock_cycle("write_read");
	end
	flush("write_read");
endtask

task automatic rotation_test();
	int n;
	idle_requests();
	req_phase = phase_width'(3);
	fill_random("rotation", num_words);
	n = addr_list.size();
	req_phase = phase_width'(4); // group 3 now belongs to the consumer.
	for (int i = 0; i < n; i++)
	begin
		req_rd_a = read_cmd(addr_list[i]);
		req_rd_b = read_cmd(addr_list[(i + 1) % n]);
		clock_cycle("rotation");
	end
	flush("rotation");
endtask

// relies on addr_list still holding the group 3 addresses.
task automatic isolation_test();
	int n;
	n = addr_list.size();
	idle_requests();
	req_phase = phase_width'(4);
	for (int i = 0; i < n; i++)
	begin
		req_wr.en = 1'b1;
		req_wr.addr = addr_list[i];
		req_wr.data = random_lanes();
		clock_cycle("isolation");
	end
	req_wr = '0;
	for (int i = 0; i < n; i++)
	begin
		req_prev_rd = read_cmd(addr_list[i]);
		req_rd_a = read_cmd(addr_list[i]);
		req_rd_b = read_cmd(addr_list[(i + 1) % n]);
		clock_cycle("isolation");
	end
	flush("isolation");
endtask

task automatic wrap_test();
	ifm_addr_t grp5_addrs [$];
	int n;
	idle_requests();
	req_phase = phase_width'(5);
	fill_random("wrap", num_words);
	grp5_addrs = addr_list;
	req_phase = '0;
	fill_random("wrap", num_words); // lands in group 0.
	n = grp5_addrs.size();
	for (int i = 0; i < n; i++)
	begin
		req_rd_a = read_cmd(grp5_addrs[i]);
		req_rd_b = read_cmd(grp5_addrs[(i + 1) % n]);
		req_prev_rd = read_cmd(addr_list[i]);
		clock_cycle("wrap");
	end
	flush("wrap");
endtask

task automatic invalid_phase_test();
	idle_requests();
	req_phase = phase_width'(1);
	fill_random("invalid_phase", num_words);
	req_phase = phase_width'(6);
	for (int a = 0; a < ifm_depth; a++)
	begin
		if (any_written(a))
		begin
			req_wr.en = 1'b1;
			req_wr.addr = ifm_addr_t'(a);
			req_wr.data = random_lanes();
			req_prev_rd = read_cmd(ifm_addr_t'(a));
			req_rd_a = read_cmd(ifm_addr_t'(a));
			req_rd_b = read_cmd(ifm_addr_t'(a));
			clock_cycle("invalid_phase");
		end
	end
	flush("invalid_phase");
	// every group must still hold what the model holds.
	for (int g = 0; g < num_groups; g++)
	begin
		req_phase = phase_width'(g);
		for (int a = 0; a < ifm_depth; a++)
		begin
			if (written[g][a])
			begin
				req_prev_rd = read_cmd(ifm_addr_t'(a));
				clock_cycle("invalid_phase");
			end
		end
	end
	flush("invalid_phase");
endtask

// ==== tb/tb_ifm_rotating_buffer.sv ====
`timescale 1ns/100ps

module tb_ifm_rotating_buffer
	import ifm_buffer_pkg::*;
();

	localparam int clk_period = 100;
	localparam int reset_cycles = 8;
	localparam int num_words = 16; // words written per group in each test.

	// cycle budget per test, used by the watchdog.
	localparam int reset_test_len = 16;
	localparam int write_read_len = 2 * num_words + 2;
	localparam int rotation_len = 2 * num_words + 2;
	localparam int isolation_len = 2 * num_words + 2;
	localparam int wrap_len = 3 * num_words + 2;
	localparam int invalid_len = 13 * num_words + 4;
	localparam int margin_cycles = 50;
	localparam int run_cycles = reset_cycles + reset_test_len + write_read_len + rotation_len
		+ isolation_len + wrap_len + invalid_len + margin_cycles;

	// expected response of one read port.
	typedef struct packed
	{
		logic valid;
		logic compare; // data is only known for addresses that were written.
		ifm_lanes_t data;
	} expect_t;

	logic clk;
	logic rst;
	logic [phase_width-1:0] phase;
	ifm_write_t prev_wr;
	ifm_read_t prev_rd;
	ifm_read_t next_rd_a;
	ifm_read_t next_rd_b;
	ifm_read_data_t prev_rd_data;
	ifm_read_data_t next_rd_a_data;
	ifm_read_data_t next_rd_b_data;

	// requests for the next cycle, set by the tests.
	logic [phase_width-1:0] req_phase;
	ifm_write_t req_wr;
	ifm_read_t req_prev_rd;
	ifm_read_t req_rd_a;
	ifm_read_t req_rd_b;

	expect_t pend_prev;
	expect_t pend_a;
	expect_t pend_b;

	ifm_word_t ref_mem [num_groups][num_lanes][ifm_depth];
	bit written [num_groups][ifm_depth];
	ifm_addr_t addr_list [$];

	logic [15:0] lfsr;
	int value_errors;
	int flag_errors;

	ifm_rotating_buffer ifm_rotating_buffer_inst
	(
		.clk(clk),
		.rst(rst),
		.phase(phase),
		.prev_wr(prev_wr),
		.prev_rd(prev_rd),
		.prev_rd_data(prev_rd_data),
		.next_rd_a(next_rd_a),
		.next_rd_b(next_rd_b),
		.next_rd_a_data(next_rd_a_data),
		.next_rd_b_data(next_rd_b_data)
	);

	// x^16 + x^14 + x^13 + x^11, one step per bit taken.
	function automatic logic [31:0] random_bits(input int n);
		logic [31:0] r;
		logic fb;
		r = '0;
		for (int i = 0; i < n; i++)
		begin
			fb = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
			lfsr = {lfsr[14:0], fb};
			r = {r[30:0], fb};
		end
		return r;
	endfunction

	function automatic ifm_addr_t random_addr();
		return ifm_addr_t'(random_bits(addr_width) % ifm_depth);
	endfunction

	function automatic ifm_lanes_t random_lanes();
		ifm_lanes_t d;
		for (int l = 0; l < num_lanes; l++)
		begin
			d[l] = random_bits(data_width);
		end
		return d;
	endfunction

	function automatic ifm_read_t read_cmd(input ifm_addr_t addr);
		ifm_read_t r;
		r.en = 1'b1;
		r.addr = addr;
		return r;
	endfunction

	function automatic expect_t predict(input logic en, input int grp, input ifm_addr_t addr,
		input logic ok);
		expect_t e;
		e = '0;
		e.valid = en && ok;
		if (e.valid && written[grp][addr])
		begin
			e.compare = 1'b1;
			for (int l = 0; l < num_lanes; l++)
			begin
				e.data[l] = ref_mem[grp][l][addr];
			end
		end
		return e;
	endfunction

	task automatic check_response(input string name, input string port, input expect_t e,
		input ifm_read_data_t r);
		assert (r.valid === e.valid)
		else
		begin
			flag_errors++;
			if (e.valid)
				$display("%s: %s gave no valid flag one cycle after its read enable.", name, port);
			else
				$display("%s: %s raised a valid flag with no read one cycle before.", name, port);
		end
		if (e.compare && r.valid)
		begin
			assert (r.data === e.data)
			else
			begin
				value_errors++;
				$display("FAILED %s %s: expected %h, actual %h", name, port, e.data, r.data);
			end
		end
	endtask

	// drives one cycle of requests and checks the responses to the cycle before.
	task automatic clock_cycle(input string name);
		logic ok;
		int pg;
		int cg;
		expect_t np;
		expect_t na;
		expect_t nb;
		pg = int'(req_phase);
		ok = !(pg inside {6, 7}); // codes 6 and 7 own no group.
		cg = (pg + num_groups - 1) % num_groups;
		np = predict(req_prev_rd.en, pg, req_prev_rd.addr, ok); // read-first against this write.
		na = predict(req_rd_a.en, cg, req_rd_a.addr, ok);
		nb = predict(req_rd_b.en, cg, req_rd_b.addr, ok);
		@(posedge clk);
		phase <= req_phase;
		prev_wr <= req_wr;
		prev_rd <= req_prev_rd;
		next_rd_a <= req_rd_a;
		next_rd_b <= req_rd_b;
		if (ok && req_wr.en)
		begin
			for (int l = 0; l < num_lanes; l++)
			begin
				ref_mem[pg][l][req_wr.addr] = req_wr.data[l];
			end
			written[pg][req_wr.addr] = 1'b1;
		end
		@(negedge clk);
		check_response(name, "prev_rd", pend_prev, prev_rd_data);
		check_response(name, "next_rd_a", pend_a, next_rd_a_data);
		check_response(name, "next_rd_b", pend_b, next_rd_b_data);
		pend_prev = np;
		pend_a = na;
		pend_b = nb;
	endtask

	`include "ifm_buffer_tests.svh"

	initial
	begin
		clk = 1'b0;
		forever #(clk_period / 2) clk = ~clk;
	end

	initial
	begin
		#(run_cycles * clk_period);
		$display("Timeout: the tests did not finish within %0d cycles.", run_cycles);
		$display("Testbench failed");
		$finish;
	end

	initial
	begin
		lfsr = 16'd65212;
		rst = 1'b1;
		phase = '0;
		prev_wr = '0;
		prev_rd = '0;
		next_rd_a = '0;
		next_rd_b = '0;
		req_phase = '0;
		req_wr = '0;
		req_prev_rd = '0;
		req_rd_a = '0;
		req_rd_b = '0;
		pend_prev = '0;
		pend_a = '0;
		pend_b = '0;
		value_errors = 0;
		flag_errors = 0;
		repeat (reset_cycles) @(posedge clk);
		rst <= 1'b0;

		reset_valid_test();
		write_read_test();
		rotation_test();
		isolation_test();
		wrap_test();
		invalid_phase_test();

		$display("errors: %0d data mismatches, %0d valid flag errors", value_errors, flag_errors);
		if (value_errors + flag_errors == 0)
			$display("Testbench passed");
		else
			$display("Testbench failed");
		$finish;
	end

endmodule

// ==== sim.f ====
source/ifm_buffer_pkg.sv
source/ifm_lane_ram.sv
source/ifm_bank_group.sv
source/ifm_bank_switch.sv
source/ifm_rotating_buffer.sv
+incdir+tb
tb/tb_ifm_rotating_buffer.sv

// ==== Makefile ====
# Verilator build and run for the rotating input feature map buffer.

VERILATOR ?= verilator
TOP ?= tb_ifm_rotating_buffer
FILELIST ?= sim.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
JOBS ?= 0
VFLAGS ?= --binary --timing --assert -j $(JOBS)

SOURCES := $(wildcard source/*.sv) $(wildcard tb/*.sv) $(wildcard tb/*.svh)
BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(BIN)

# rebuilt only when a source or the file list changes.
$(BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "Testbench passed" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
